// File: hdl/core_pkg.sv
package core_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [11:0] apb_addr_t;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_IMM
  } alu_op_t;

  // operand immediate: I-type for ADDI, U-type for LUI
  typedef enum logic {
    IMM_I,
    IMM_U
  } imm_kind_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXECUTE,
    ST_HALTED
  } core_state_t;

  //////////////////////////////
  // instruction encodings
  //////////////////////////////

  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // funct12 of the SYSTEM group
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;

  //////////////////////////////
  // APB register map
  //////////////////////////////

  localparam apb_addr_t REG_CTRL      = 12'h000;
  localparam apb_addr_t REG_STATUS    = 12'h004;
  localparam apb_addr_t REG_MTVEC     = 12'h008;
  localparam apb_addr_t REG_CYCLES    = 12'h00C;
  localparam apb_addr_t REG_INSTRET   = 12'h010;
  localparam apb_addr_t REG_PC        = 12'h014;
  localparam apb_addr_t REG_GPR_BASE  = 12'h080;
  localparam apb_addr_t REG_IMEM_BASE = 12'h400;

  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_STOP_BIT  = 1;

endpackage

// File: hdl/apb_debug_port.sv
`timescale 1ns/1ps

module apb_debug_port import core_pkg::*; #(
  parameter int IMEM_WORDS = 256
) (
  input  logic      clk,
  input  logic      rst,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  word_t     pwdata,
  output word_t     prdata,
  output logic      pready,
  output logic      pslverr,
  input  addr_t     fetch_pc,
  input  logic      running,
  input  logic      halted,
  input  logic      illegal,
  input  logic      trapping,
  input  word_t     cycles,
  input  word_t     instret,
  input  word_t     dbg_rdata,
  output word_t     instr,
  output logic      start,
  output logic      stop,
  output addr_t     mtvec,
  output reg_idx_t  dbg_idx
);

  localparam int IDX_W = $clog2(IMEM_WORDS);

  word_t            imem [IMEM_WORDS];
  logic             access;
  logic             wr_en;
  logic             rd_en;
  apb_addr_t        imem_off;
  logic             imem_hit;
  logic             gpr_hit;
  logic             write_blocked;
  logic [IDX_W-1:0] apb_idx;
  logic [IDX_W-1:0] fetch_idx;

  // no wait states, every access completes in its access phase
  assign pready = 1'b1;
  assign access = psel && penable;
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;

  // address decode
  assign imem_off  = paddr - REG_IMEM_BASE;
  assign imem_hit  = (paddr >= REG_IMEM_BASE) && (32'(imem_off[11:2]) < IMEM_WORDS);
  assign apb_idx   = imem_off[IDX_W+1:2];
  assign gpr_hit   = paddr[11:7] == REG_GPR_BASE[11:7];
  assign dbg_idx   = paddr[6:2];
  assign fetch_idx = fetch_pc[IDX_W+1:2];

  // program and trap vector are frozen while the core runs
  assign write_blocked = running && (imem_hit || paddr == REG_MTVEC);
  assign pslverr       = wr_en && write_blocked;

  assign start = wr_en && paddr == REG_CTRL && pwdata[CTRL_START_BIT];
  assign stop  = wr_en && paddr == REG_CTRL && pwdata[CTRL_STOP_BIT];

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec <= '0;
    end else if (wr_en && !write_blocked && paddr == REG_MTVEC) begin
      mtvec <= pwdata;
    end
  end

  // instruction memory, APB write port and synchronous fetch port
  always_ff @(posedge clk) begin
    if (wr_en && !write_blocked && imem_hit) begin
      imem[apb_idx] <= pwdata;
    end
    instr <= imem[fetch_idx];
  end

  // readback
  always_comb begin
    prdata = '0;
    if (rd_en) begin
      if (gpr_hit) begin
        prdata = dbg_rdata;
      end else if (imem_hit) begin
        prdata = imem[apb_idx];
      end else begin
        case (paddr)
          REG_STATUS:  prdata = {28'd0, illegal, trapping, halted, running};
          REG_MTVEC:   prdata = mtvec;
          REG_CYCLES:  prdata = cycles;
          REG_INSTRET: prdata = instret;
          REG_PC:      prdata = fetch_pc;
          default:     prdata = '0;
        endcase
      end
    end
  end

endmodule

// File: hdl/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl import core_pkg::*; #(
  parameter int IMEM_WORDS = 256
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      stop,
  input  word_t     instr,
  output addr_t     fetch_pc,
  output logic      running,
  output logic      halted,
  output logic      illegal,
  output logic      start_cycle,
  output logic      instr_done,
  output reg_idx_t  rs1_idx,
  output reg_idx_t  rs2_idx,
  output reg_idx_t  rd_idx,
  output logic      rd_we,
  output alu_op_t   alu_op,
  output logic      alu_use_imm,
  output imm_kind_t imm_kind,
  output logic      br_ne,
  output logic      is_branch,
  output logic      ecall_taken,
  output logic      mret_taken,
  input  logic      br_taken,
  input  word_t     br_offset,
  input  logic      trapping,
  input  addr_t     trap_target,
  input  addr_t     return_target
);

  localparam int IDX_W = $clog2(IMEM_WORDS);

  core_state_t state;
  addr_t       pc;
  addr_t       next_raw;
  addr_t       next_pc;
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;
  logic        writes_rd;
  logic        is_ecall;
  logic        is_ebreak;
  logic        is_mret;
  logic        is_illegal;
  logic        in_exec;
  logic        stop_here;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign funct12 = instr[31:20];
  assign rd_idx  = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign br_ne   = funct3[0];

  //////////////////////////////
  // decode
  //////////////////////////////

  always_comb begin
    writes_rd   = 1'b0;
    alu_op      = ALU_ADD;
    alu_use_imm = 1'b0;
    imm_kind    = IMM_I;
    is_branch   = 1'b0;
    is_ecall    = 1'b0;
    is_ebreak   = 1'b0;
    is_mret     = 1'b0;
    is_illegal  = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        writes_rd   = funct3 == F3_ADD;
        alu_use_imm = 1'b1;
        is_illegal  = funct3 != F3_ADD;
      end
      OPC_OP: begin
        writes_rd  = funct3 == F3_ADD && (funct7 == F7_ADD || funct7 == F7_SUB);
        alu_op     = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
        is_illegal = !writes_rd;
      end
      OPC_LUI: begin
        writes_rd   = 1'b1;
        alu_op      = ALU_PASS_IMM;
        alu_use_imm = 1'b1;
        imm_kind    = IMM_U;
      end
      OPC_BRANCH: begin
        is_branch  = funct3 == F3_BEQ || funct3 == F3_BNE;
        is_illegal = !is_branch;
      end
      OPC_SYSTEM: begin
        // rd, rs1 and funct3 must all be zero
        if (instr[19:7] == '0) begin
          is_ecall   = funct12 == SYS_ECALL;
          is_ebreak  = funct12 == SYS_EBREAK;
          is_mret    = funct12 == SYS_MRET;
        end
        is_illegal = !(is_ecall || is_ebreak || is_mret);
      end
      default: is_illegal = 1'b1;
    endcase
  end

  //////////////////////////////
  // sequencing
  //////////////////////////////

  assign in_exec     = state == ST_EXECUTE;
  assign running     = state == ST_FETCH || state == ST_EXECUTE;
  assign halted      = state == ST_HALTED;
  assign start_cycle = start && (state == ST_IDLE || state == ST_HALTED);
  assign instr_done  = in_exec;
  assign rd_we       = in_exec && writes_rd;
  assign ecall_taken = in_exec && is_ecall;
  assign mret_taken  = in_exec && is_mret;
  assign fetch_pc    = pc;
  // ebreak and illegal words leave the pc on themselves
  assign stop_here   = is_ebreak || is_illegal;

  always_comb begin
    if (is_ecall && !trapping) begin
      next_raw = trap_target;
    end else if (is_mret && trapping) begin
      next_raw = return_target;
    end else if (is_branch && br_taken) begin
      next_raw = pc + br_offset;
    end else begin
      next_raw = pc + 32'd4;
    end
  end

  // wrap inside instruction memory
  assign next_pc = addr_t'({next_raw[IDX_W+1:2], 2'b00});

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      pc      <= '0;
      illegal <= 1'b0;
    end else begin
      case (state)
        ST_IDLE, ST_HALTED: begin
          if (start) begin
            state   <= ST_FETCH;
            pc      <= '0;
            illegal <= 1'b0;
          end
        end
        ST_FETCH: state <= stop ? ST_HALTED : ST_EXECUTE;
        ST_EXECUTE: begin
          if (!stop_here) begin
            pc <= next_pc;
          end
          illegal <= is_illegal;
          state   <= (stop || stop_here) ? ST_HALTED : ST_FETCH;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
  input  word_t     instr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  alu_op_t   alu_op,
  input  logic      alu_use_imm,
  input  imm_kind_t imm_kind,
  input  logic      br_ne,
  input  addr_t     pc,
  output word_t     result,
  output logic      br_taken,
  output word_t     br_offset
);

  word_t imm_i;
  word_t imm_u;
  word_t imm_b;
  word_t op_b;
  addr_t br_target;
  logic  equal;

  // immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  assign op_b = alu_use_imm ? ((imm_kind == IMM_U) ? imm_u : imm_i) : rs2_data;

  always_comb begin
    case (alu_op)
      ALU_SUB:      result = rs1_data - op_b;
      ALU_PASS_IMM: result = op_b;
      default:      result = rs1_data + op_b;
    endcase
  end

  // branch compare
  assign equal     = rs1_data == rs2_data;
  assign br_offset = imm_b;
  assign br_target = pc + imm_b;
  // a target off the word grid falls through
  assign br_taken  = (br_ne ? !equal : equal) && br_target[1:0] == 2'b00;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  reg_idx_t dbg_idx,
  input  reg_idx_t rd_idx,
  input  logic     rd_we,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output word_t    dbg_rdata
);

  word_t regs [32];

  // x0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // core read ports
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  // debug port, independent of the core
  assign dbg_rdata = regs[dbg_idx];

endmodule

// File: hdl/trap_unit.sv
`timescale 1ns/1ps

module trap_unit import core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  ecall_taken,
  input  logic  mret_taken,
  input  addr_t pc,
  input  addr_t mtvec,
  output logic  trapping,
  output addr_t trap_target,
  output addr_t return_target
);

  addr_t mepc;

  // nested ecall is ignored, trap state holds until mret
  always_ff @(posedge clk) begin
    if (rst) begin
      trapping <= 1'b0;
    end else if (start) begin
      trapping <= 1'b0;
    end else if (ecall_taken && !trapping) begin
      trapping <= 1'b1;
    end else if (mret_taken && trapping) begin
      trapping <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ecall_taken && !trapping) begin
      mepc <= pc;
    end
  end

  assign trap_target = mtvec;

  // resume after the ecall itself
  assign return_target = mepc + 32'd4;

endmodule

// File: hdl/perf_counters.sv
`timescale 1ns/1ps

module perf_counters import core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  running,
  input  logic  instr_done,
  output word_t cycles,
  output word_t instret
);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycles  <= '0;
      instret <= '0;
    end else if (start) begin
      cycles  <= '0;
      instret <= '0;
    end else if (running) begin
      cycles <= cycles + 32'd1;
      // one retire per execute cycle
      if (instr_done) begin
        instret <= instret + 32'd1;
      end
    end
  end

endmodule

// File: hdl/mini_core_top.sv
`timescale 1ns/1ps

module mini_core_top import core_pkg::*; #(
  parameter int IMEM_WORDS = 256
) (
  input  logic      clk,
  input  logic      rst,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  word_t     pwdata,
  output word_t     prdata,
  output logic      pready,
  output logic      pslverr
);

  word_t     instr;
  addr_t     fetch_pc;
  addr_t     mtvec;
  addr_t     trap_target;
  addr_t     return_target;
  logic      start;
  logic      stop;
  logic      running;
  logic      halted;
  logic      illegal;
  logic      trapping;
  logic      start_cycle;
  logic      instr_done;
  logic      ecall_taken;
  logic      mret_taken;
  word_t     cycles;
  word_t     instret;
  reg_idx_t  dbg_idx;
  word_t     dbg_rdata;
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  reg_idx_t  rd_idx;
  logic      rd_we;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     result;
  alu_op_t   alu_op;
  logic      alu_use_imm;
  imm_kind_t imm_kind;
  logic      br_ne;
  logic      br_taken;
  word_t     br_offset;

  //////////////////////////////
  // bus side
  //////////////////////////////

  apb_debug_port #(
    .IMEM_WORDS(IMEM_WORDS)
  ) i_apb (
    .clk(clk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .fetch_pc(fetch_pc), .running(running), .halted(halted),
    .illegal(illegal), .trapping(trapping),
    .cycles(cycles), .instret(instret), .dbg_rdata(dbg_rdata),
    .instr(instr), .start(start), .stop(stop), .mtvec(mtvec), .dbg_idx(dbg_idx)
  );

  //////////////////////////////
  // core
  //////////////////////////////

  // is_branch is consumed inside the controller only
  core_ctrl #(
    .IMEM_WORDS(IMEM_WORDS)
  ) i_ctrl (
    .clk(clk), .rst(rst), .start(start), .stop(stop), .instr(instr),
    .fetch_pc(fetch_pc), .running(running), .halted(halted), .illegal(illegal),
    .start_cycle(start_cycle), .instr_done(instr_done),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx), .rd_we(rd_we),
    .alu_op(alu_op), .alu_use_imm(alu_use_imm), .imm_kind(imm_kind),
    .br_ne(br_ne), .is_branch(), .ecall_taken(ecall_taken), .mret_taken(mret_taken),
    .br_taken(br_taken), .br_offset(br_offset), .trapping(trapping),
    .trap_target(trap_target), .return_target(return_target)
  );

  exec_unit i_exec (
    .instr(instr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .alu_op(alu_op), .alu_use_imm(alu_use_imm), .imm_kind(imm_kind),
    .br_ne(br_ne), .pc(fetch_pc),
    .result(result), .br_taken(br_taken), .br_offset(br_offset)
  );

  reg_file i_regs (
    .clk(clk), .rst(rst),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .dbg_idx(dbg_idx),
    .rd_idx(rd_idx), .rd_we(rd_we), .rd_data(result),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .dbg_rdata(dbg_rdata)
  );

  trap_unit i_trap (
    .clk(clk), .rst(rst), .start(start_cycle),
    .ecall_taken(ecall_taken), .mret_taken(mret_taken),
    .pc(fetch_pc), .mtvec(mtvec),
    .trapping(trapping), .trap_target(trap_target), .return_target(return_target)
  );

  perf_counters i_perf (
    .clk(clk), .rst(rst), .start(start_cycle),
    .running(running), .instr_done(instr_done),
    .cycles(cycles), .instret(instret)
  );

endmodule

// File: tests/tb_mini_core_sva.sv
`timescale 1ns/1ps

module tb_mini_core_sva (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic running,
  input logic halted
);

  int fail_count;

  initial fail_count = 0;

  // zero wait states on every cycle
  a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
    else begin
      fail_count++;
      $error("pready is low");
    end

  a_run_halt_excl: assert property (@(posedge clk) disable iff (rst) !(running && halted))
    else begin
      fail_count++;
      $error("running and halted are both set");
    end

  // slave error only in the access phase
  a_err_in_access: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> (psel && penable))
    else begin
      fail_count++;
      $error("pslverr outside an access phase");
    end

endmodule

bind mini_core_top tb_mini_core_sva i_sva (
  .clk(clk), .rst(rst), .psel(psel), .penable(penable),
  .pready(pready), .pslverr(pslverr), .running(running), .halted(halted)
);

// File: tests/tb_mini_core.sv
`timescale 1ns/1ps

module tb_mini_core import core_pkg::*; ();

  localparam int NUM_PROGS  = 8;
  localparam int IMEM_WORDS = 256;
  // per program about 40 writes and 35 reads of 3 cycles each, a run under 100
  // cycles plus polling; directed cases and a wide margin on top
  localparam int TIMEOUT_CYCLES = (NUM_PROGS + 2) * 2000;
  localparam addr_t PC_MASK     = addr_t'(IMEM_WORDS * 4 - 4);

  localparam word_t ECALL_W  = 32'h0000_0073;
  localparam word_t EBREAK_W = 32'h0010_0073;
  localparam word_t MRET_W   = 32'h3020_0073;

  logic      clk;
  logic      rst;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  word_t     pwdata;
  word_t     prdata;
  logic      pready;
  logic      pslverr;

  logic [31:0] lfsr;
  int          checks;
  int          mismatches;
  int          other_errors;
  word_t       prog_mem [IMEM_WORDS];
  word_t       model_regs [32];
  int          model_retired;
  addr_t       model_pc;
  logic        model_trap;

  mini_core_top #(
    .IMEM_WORDS(IMEM_WORDS)
  ) i_dut (
    .clk(clk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic word_t rand_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  //////////////////////////////
  // instruction encoders
  //////////////////////////////

  function automatic word_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic word_t rtype_word(input logic sub, input reg_idx_t rd,
                                       input reg_idx_t rs1, input reg_idx_t rs2);
    return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t lui_word(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t branch_word(input logic ne, input reg_idx_t rs1,
                                        input reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
  endfunction

  //////////////////////////////
  // APB access
  //////////////////////////////

  task automatic apb_xfer(input apb_addr_t addr, input logic wr, input word_t wdata,
                          output word_t rdata, output logic err);
    @(posedge clk);
    #2;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    // access phase, sampled mid-cycle
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_ok(input apb_addr_t addr, input word_t data);
    word_t rd;
    logic  err;
    apb_xfer(addr, 1'b1, data, rd, err);
    if (err) begin
      other_errors++;
      $display("ERROR: write to 0x%03h was rejected with a slave error", addr);
    end
  endtask

  task automatic read_expect(input string name, input apb_addr_t addr, input word_t exp);
    word_t rd;
    logic  err;
    apb_xfer(addr, 1'b0, '0, rd, err);
    checks++;
    if (rd !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, rd);
    end
  endtask

  task automatic put_word(input int idx, input word_t w);
    prog_mem[idx] = w;
    write_ok(REG_IMEM_BASE + apb_addr_t'(idx * 4), w);
  endtask

  task automatic start_core();
    write_ok(REG_CTRL, 32'h1);
  endtask

  task automatic wait_halted();
    word_t st;
    logic  err;
    st = '0;
    while (!st[1]) begin
      apb_xfer(REG_STATUS, 1'b0, '0, st, err);
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  task automatic set_model_reg(input reg_idx_t rd, input word_t val);
    if (rd != 5'd0) begin
      model_regs[rd] = val;
    end
  endtask

  task automatic run_model(input addr_t trap_vec);
    addr_t pc;
    addr_t nxt;
    addr_t mepc;
    word_t w;
    word_t a;
    word_t b;
    logic  done;
    pc            = '0;
    mepc          = '0;
    done          = 1'b0;
    model_retired = 0;
    model_trap    = 1'b0;
    while (!done && model_retired < 1000) begin
      w   = prog_mem[int'(pc >> 2)];
      a   = model_regs[w[19:15]];
      b   = model_regs[w[24:20]];
      nxt = pc + 32'd4;
      model_retired++;
      case (w[6:0])
        7'b0010011: set_model_reg(w[11:7], a + {{20{w[31]}}, w[31:20]});
        7'b0110011: set_model_reg(w[11:7], w[30] ? a - b : a + b);
        7'b0110111: set_model_reg(w[11:7], {w[31:12], 12'd0});
        7'b1100011: begin
          // funct3 bit 0 picks bne
          if ((a == b) != w[12]) begin
            nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: begin
          if (w == ECALL_W) begin
            if (!model_trap) begin
              mepc       = pc;
              model_trap = 1'b1;
              nxt        = trap_vec;
            end
          end else if (w == MRET_W) begin
            if (model_trap) begin
              model_trap = 1'b0;
              nxt        = mepc + 32'd4;
            end
          end else begin
            done = 1'b1;
          end
        end
      endcase
      if (!done) begin
        pc = nxt & PC_MASK;
      end
    end
    model_pc = pc;
  endtask

  //////////////////////////////
  // random programs
  //////////////////////////////

  task automatic build_program(input logic with_mret, output addr_t vec);
    int       n;
    int       e;
    int       h;
    int       limit;
    word_t    kind;
    word_t    w;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    n = 20 + int'(rand_bits(4) % 11);
    // the ecall slot, every branch before it stops at or before it
    e = 1 + int'(rand_bits(5) % (n - 2));
    for (int i = 0; i < n - 1; i++) begin
      kind  = rand_bits(3);
      rd    = 5'(1 + rand_bits(5) % 30);
      rs1   = 5'(rand_bits(5));
      rs2   = rand_bits(1) != 0 ? rs1 : 5'(rand_bits(5));
      limit = (i < e) ? e : n - 1;
      if (i == e) begin
        w = ECALL_W;
      end else begin
        case (kind)
          32'd2: w = rtype_word(1'b0, rd, rs1, rs2);
          32'd3: w = rtype_word(1'b1, rd, rs1, rs2);
          32'd4: w = lui_word(rd, 20'(rand_bits(20)));
          32'd5, 32'd6: begin
            w = branch_word(1'(rand_bits(1)), rs1, rs2,
                            13'((1 + rand_bits(5) % (limit - i)) * 4));
          end
          default: w = addi_word(rd, rs1, 12'(rand_bits(12)));
        endcase
      end
      put_word(i, w);
    end
    put_word(n - 1, EBREAK_W);
    // handler above the program, writes x31 only
    h = n + 2 + int'(rand_bits(7));
    put_word(h, addi_word(5'd31, 5'(rand_bits(5) % 31), 12'(rand_bits(12))));
    put_word(h + 1, with_mret ? MRET_W : EBREAK_W);
    vec = addr_t'(h * 4);
    write_ok(REG_MTVEC, vec);
  endtask

  task automatic run_random_program(input int p);
    logic  with_mret;
    addr_t vec;
    word_t exp_status;
    string tag;
    tag       = $sformatf("prog%0d", p);
    with_mret = p != NUM_PROGS - 1;
    build_program(with_mret, vec);
    run_model(vec);
    start_core();
    wait_halted();
    // trapping stays set only when the handler has no mret
    exp_status = {28'd0, 1'b0, model_trap, 1'b1, 1'b0};
    read_expect({tag, " status"}, REG_STATUS, exp_status);
    read_expect({tag, " instret"}, REG_INSTRET, word_t'(model_retired));
    read_expect({tag, " cycles"}, REG_CYCLES, word_t'(2 * model_retired));
    read_expect({tag, " pc"}, REG_PC, model_pc);
    for (int r = 1; r < 32; r++) begin
      read_expect($sformatf("%s x%0d", tag, r), REG_GPR_BASE + apb_addr_t'(r * 4),
                  model_regs[r]);
    end
  endtask

  //////////////////////////////
  // directed cases
  //////////////////////////////

  task automatic illegal_halt();
    put_word(0, addi_word(5'd1, 5'd0, 12'd5));
    put_word(1, 32'hFFFF_FFFF);
    start_core();
    wait_halted();
    read_expect("illegal status", REG_STATUS, 32'hA);
    read_expect("illegal pc", REG_PC, 32'h4);
    read_expect("illegal instret", REG_INSTRET, 32'd2);
    read_expect("illegal x1", REG_GPR_BASE + 12'h004, 32'd5);
  endtask

  task automatic protect_while_running();
    word_t rd;
    logic  err;
    write_ok(REG_MTVEC, 32'h100);
    // beq x0, x0 onto itself keeps the core busy
    put_word(0, branch_word(1'b0, 5'd0, 5'd0, 13'd0));
    start_core();
    apb_xfer(REG_IMEM_BASE, 1'b1, EBREAK_W, rd, err);
    checks++;
    if (!err) begin
      other_errors++;
      $display("ERROR: instruction memory write while running gave no slave error");
    end
    apb_xfer(REG_MTVEC, 1'b1, 32'h200, rd, err);
    checks++;
    if (!err) begin
      other_errors++;
      $display("ERROR: trap vector write while running gave no slave error");
    end
    read_expect("protect imem", REG_IMEM_BASE, prog_mem[0]);
    read_expect("protect mtvec", REG_MTVEC, 32'h100);
    read_expect("protect status", REG_STATUS, 32'h1);
  endtask

  task automatic stop_and_restart();
    word_t first;
    word_t again;
    logic  err;
    write_ok(REG_CTRL, 32'h2);
    read_expect("stop status", REG_STATUS, 32'h2);
    apb_xfer(REG_INSTRET, 1'b0, '0, first, err);
    checks++;
    if (first == '0) begin
      other_errors++;
      $display("ERROR: no instruction retired before the core was stopped");
    end
    // counters hold while halted
    apb_xfer(REG_CYCLES, 1'b0, '0, first, err);
    read_expect("stop cycles hold", REG_CYCLES, first);
    put_word(0, EBREAK_W);
    start_core();
    wait_halted();
    read_expect("restart status", REG_STATUS, 32'h2);
    read_expect("restart instret", REG_INSTRET, 32'd1);
    read_expect("restart cycles", REG_CYCLES, 32'd2);
    read_expect("restart pc", REG_PC, 32'h0);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    lfsr         = 32'h2c18b706;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    rst          = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    read_expect("reset status", REG_STATUS, 32'h0);
    read_expect("reset cycles", REG_CYCLES, 32'h0);
    read_expect("reset instret", REG_INSTRET, 32'h0);
    for (int r = 0; r < 32; r++) begin
      read_expect($sformatf("reset x%0d", r), REG_GPR_BASE + apb_addr_t'(r * 4), 32'h0);
    end

    for (int p = 0; p < NUM_PROGS; p++) begin
      run_random_program(p);
    end
    illegal_halt();
    protect_while_running();
    stop_and_restart();

    $display("checks=%0d mismatches=%0d other_errors=%0d assertion_failures=%0d",
             checks, mismatches, other_errors, i_dut.i_sva.fail_count);
    if (mismatches == 0 && other_errors == 0 && i_dut.i_sva.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: files.f
hdl/core_pkg.sv
hdl/apb_debug_port.sv
hdl/core_ctrl.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/trap_unit.sv
hdl/perf_counters.sv
hdl/mini_core_top.sv
tests/tb_mini_core_sva.sv
tests/tb_mini_core.sv
